//--- axi2obi/axi2obi.sv
`timescale 1ns/1ps

module axi2obi #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                        s00_axi_aclk,
  input  logic                        reset_i,

  // AXI4-Lite write address and data
  input  logic [ADDR_WIDTH-1:0]       s00_axi_awaddr_i,
  input  logic [axil_pkg::PROT_W-1:0] s00_axi_awprot_i,
  input  logic                        s00_axi_awvalid_i,
  output logic                        s00_axi_awready_o,
  input  logic [DATA_WIDTH-1:0]       s00_axi_wdata_i,
  input  logic [obi_pkg::BE_W-1:0]    s00_axi_wstrb_i,
  input  logic                        s00_axi_wvalid_i,
  output logic                        s00_axi_wready_o,

  // AXI4-Lite write response
  output logic [axil_pkg::RESP_W-1:0] s00_axi_bresp_o,
  output logic                        s00_axi_bvalid_o,
  input  logic                        s00_axi_bready_i,

  // AXI4-Lite read address and data
  input  logic [ADDR_WIDTH-1:0]       s00_axi_araddr_i,
  input  logic [axil_pkg::PROT_W-1:0] s00_axi_arprot_i,
  input  logic                        s00_axi_arvalid_i,
  output logic                        s00_axi_arready_o,
  output logic [DATA_WIDTH-1:0]       s00_axi_rdata_o,
  output logic [axil_pkg::RESP_W-1:0] s00_axi_rresp_o,
  output logic                        s00_axi_rvalid_o,
  input  logic                        s00_axi_rready_i,

  // OBI manager side
  output logic                        req_o,
  input  logic                        gnt_i,
  output logic                        we_o,
  output logic [obi_pkg::BE_W-1:0]    be_o,
  output logic [ADDR_WIDTH-1:0]       addr_o,
  output logic [DATA_WIDTH-1:0]       wdata_o,
  input  logic                        rvalid_i,
  input  logic [DATA_WIDTH-1:0]       rdata_i,
  input  logic                        err_i
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    RESP
  } state_e;

  state_e                        state_q;
  logic                          is_write_q;
  logic [ADDR_WIDTH-1:0]         addr_q;
  logic [DATA_WIDTH-1:0]         wdata_q;
  logic [obi_pkg::BE_W-1:0]      strb_q;
  logic [DATA_WIDTH-1:0]         rdata_q;
  logic [axil_pkg::RESP_W-1:0]   resp_q;
  logic                          ar_hs;
  logic                          aw_hs;
  logic                          resp_done;

  // Read wins when both address channels are valid in IDLE
  assign ar_hs = (state_q == IDLE) && s00_axi_arvalid_i;
  assign aw_hs = (state_q == IDLE) && !s00_axi_arvalid_i &&
                 s00_axi_awvalid_i && s00_axi_wvalid_i;

  assign s00_axi_arready_o = ar_hs;
  assign s00_axi_awready_o = aw_hs;
  assign s00_axi_wready_o  = aw_hs;

  assign resp_done = is_write_q ? s00_axi_bready_i : s00_axi_rready_i;

  // The prot fields are not checked
  always_ff @(posedge s00_axi_aclk) begin
    if (reset_i) begin
      state_q    <= IDLE;
      is_write_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            state_q    <= REQ;
            is_write_q <= 1'b0;
          end else if (aw_hs) begin
            state_q    <= REQ;
            is_write_q <= 1'b1;
          end
        end
        REQ: begin
          if (gnt_i) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (rvalid_i) begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (resp_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Latch request fields on acceptance
  always_ff @(posedge s00_axi_aclk) begin
    if (ar_hs) begin
      addr_q <= s00_axi_araddr_i;
    end else if (aw_hs) begin
      addr_q  <= s00_axi_awaddr_i;
      wdata_q <= s00_axi_wdata_i;
      strb_q  <= s00_axi_wstrb_i;
    end
  end

  // Capture the OBI response for the AXI side
  always_ff @(posedge s00_axi_aclk) begin
    if ((state_q == WAIT) && rvalid_i) begin
      rdata_q <= rdata_i;
      resp_q  <= err_i ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  assign req_o   = (state_q == REQ);
  assign we_o    = is_write_q;
  assign be_o    = is_write_q ? strb_q : '1;
  assign addr_o  = addr_q;
  assign wdata_o = wdata_q;

  assign s00_axi_rvalid_o = (state_q == RESP) && !is_write_q;
  assign s00_axi_rdata_o  = rdata_q;
  assign s00_axi_rresp_o  = resp_q;
  assign s00_axi_bvalid_o = (state_q == RESP) && is_write_q;
  assign s00_axi_bresp_o  = resp_q;

endmodule

//--- common/axil_pkg.sv
package axil_pkg;

  // Response field width on the B and R channels
  localparam int unsigned RESP_W = 2;

  // Protection field width on AW and AR
  localparam int unsigned PROT_W = 3;

  // Response codes used by this slave
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

//--- common/obi_pkg.sv
package obi_pkg;

  // Bus data width and byte enables
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // Address map
  localparam logic [31:0] SRAM_BASE = 32'h0000_0000;
  localparam logic [31:0] REGS_BASE = 32'h0000_1000;
  localparam int unsigned REGS_SIZE = 16;

  // Register window offset field, enough for the 16 byte window
  localparam int unsigned REG_OFS_W = 4;

  // Register byte offsets, 0xC is reserved
  localparam logic [REG_OFS_W-1:0] REG_ID_OFS      = 4'h0;
  localparam logic [REG_OFS_W-1:0] REG_SCRATCH_OFS = 4'h4;
  localparam logic [REG_OFS_W-1:0] REG_WCOUNT_OFS  = 4'h8;

endpackage

//--- logic/axil_obi_subsys.sv
`timescale 1ns/1ps

module axil_obi_subsys #(
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    DATA_WIDTH = obi_pkg::DATA_W,
  parameter int                    SRAM_DEPTH = 256,
  parameter logic [DATA_WIDTH-1:0] ID_VALUE   = '0
) (
  input  logic                        s00_axi_aclk,
  input  logic                        reset_i,
  input  logic [ADDR_WIDTH-1:0]       s00_axi_awaddr_i,
  input  logic [axil_pkg::PROT_W-1:0] s00_axi_awprot_i,
  input  logic                        s00_axi_awvalid_i,
  output logic                        s00_axi_awready_o,
  input  logic [DATA_WIDTH-1:0]       s00_axi_wdata_i,
  input  logic [obi_pkg::BE_W-1:0]    s00_axi_wstrb_i,
  input  logic                        s00_axi_wvalid_i,
  output logic                        s00_axi_wready_o,
  output logic [axil_pkg::RESP_W-1:0] s00_axi_bresp_o,
  output logic                        s00_axi_bvalid_o,
  input  logic                        s00_axi_bready_i,
  input  logic [ADDR_WIDTH-1:0]       s00_axi_araddr_i,
  input  logic [axil_pkg::PROT_W-1:0] s00_axi_arprot_i,
  input  logic                        s00_axi_arvalid_i,
  output logic                        s00_axi_arready_o,
  output logic [DATA_WIDTH-1:0]       s00_axi_rdata_o,
  output logic [axil_pkg::RESP_W-1:0] s00_axi_rresp_o,
  output logic                        s00_axi_rvalid_o,
  input  logic                        s00_axi_rready_i
);

  // Bridge to splitter
  logic                     m_req, m_gnt, m_we, m_rvalid, m_err;
  logic [obi_pkg::BE_W-1:0] m_be;
  logic [ADDR_WIDTH-1:0]    m_addr;
  logic [DATA_WIDTH-1:0]    m_wdata, m_rdata;

  // Splitter to targets
  logic                     sram_req, sram_gnt, sram_we, sram_rvalid, sram_err;
  logic [obi_pkg::BE_W-1:0] sram_be;
  logic [ADDR_WIDTH-1:0]    sram_addr;
  logic [DATA_WIDTH-1:0]    sram_wdata, sram_rdata;
  logic                     regs_req, regs_gnt, regs_we, regs_rvalid, regs_err;
  logic [obi_pkg::BE_W-1:0] regs_be;
  logic [ADDR_WIDTH-1:0]    regs_addr;
  logic [DATA_WIDTH-1:0]    regs_wdata, regs_rdata;

  axi2obi #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) axi2obi_i (
    .s00_axi_aclk, .reset_i,
    .s00_axi_awaddr_i, .s00_axi_awprot_i, .s00_axi_awvalid_i, .s00_axi_awready_o,
    .s00_axi_wdata_i, .s00_axi_wstrb_i, .s00_axi_wvalid_i, .s00_axi_wready_o,
    .s00_axi_bresp_o, .s00_axi_bvalid_o, .s00_axi_bready_i,
    .s00_axi_araddr_i, .s00_axi_arprot_i, .s00_axi_arvalid_i, .s00_axi_arready_o,
    .s00_axi_rdata_o, .s00_axi_rresp_o, .s00_axi_rvalid_o, .s00_axi_rready_i,
    .req_o(m_req), .gnt_i(m_gnt), .we_o(m_we), .be_o(m_be), .addr_o(m_addr),
    .wdata_o(m_wdata), .rvalid_i(m_rvalid), .rdata_i(m_rdata), .err_i(m_err)
  );

  obi_splitter #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .SRAM_DEPTH(SRAM_DEPTH)
  ) obi_splitter_i (
    .s00_axi_aclk, .reset_i,
    .m_req_i(m_req), .m_gnt_o(m_gnt), .m_we_i(m_we), .m_be_i(m_be),
    .m_addr_i(m_addr), .m_wdata_i(m_wdata),
    .m_rvalid_o(m_rvalid), .m_rdata_o(m_rdata), .m_err_o(m_err),
    .sram_req_o(sram_req), .sram_gnt_i(sram_gnt), .sram_we_o(sram_we),
    .sram_be_o(sram_be), .sram_addr_o(sram_addr), .sram_wdata_o(sram_wdata),
    .sram_rvalid_i(sram_rvalid), .sram_rdata_i(sram_rdata), .sram_err_i(sram_err),
    .regs_req_o(regs_req), .regs_gnt_i(regs_gnt), .regs_we_o(regs_we),
    .regs_be_o(regs_be), .regs_addr_o(regs_addr), .regs_wdata_o(regs_wdata),
    .regs_rvalid_i(regs_rvalid), .regs_rdata_i(regs_rdata), .regs_err_i(regs_err)
  );

  obi_sram #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .SRAM_DEPTH(SRAM_DEPTH)
  ) obi_sram_i (
    .s00_axi_aclk,
    .req_i(sram_req), .gnt_o(sram_gnt), .we_i(sram_we), .be_i(sram_be),
    .addr_i(sram_addr), .wdata_i(sram_wdata),
    .rvalid_o(sram_rvalid), .rdata_o(sram_rdata), .err_o(sram_err)
  );

  obi_status_regs #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_VALUE  (ID_VALUE)
  ) obi_status_regs_i (
    .s00_axi_aclk, .reset_i,
    .req_i(regs_req), .gnt_o(regs_gnt), .we_i(regs_we), .be_i(regs_be),
    .addr_i(regs_addr), .wdata_i(regs_wdata),
    .rvalid_o(regs_rvalid), .rdata_o(regs_rdata), .err_o(regs_err)
  );

endmodule

//--- logic/obi_splitter.sv
`timescale 1ns/1ps

module obi_splitter #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int SRAM_DEPTH = 256
) (
  input  logic                     s00_axi_aclk,
  input  logic                     reset_i,

  // From the bridge
  input  logic                     m_req_i,
  output logic                     m_gnt_o,
  input  logic                     m_we_i,
  input  logic [obi_pkg::BE_W-1:0] m_be_i,
  input  logic [ADDR_WIDTH-1:0]    m_addr_i,
  input  logic [DATA_WIDTH-1:0]    m_wdata_i,
  output logic                     m_rvalid_o,
  output logic [DATA_WIDTH-1:0]    m_rdata_o,
  output logic                     m_err_o,

  // SRAM target
  output logic                     sram_req_o,
  input  logic                     sram_gnt_i,
  output logic                     sram_we_o,
  output logic [obi_pkg::BE_W-1:0] sram_be_o,
  output logic [ADDR_WIDTH-1:0]    sram_addr_o,
  output logic [DATA_WIDTH-1:0]    sram_wdata_o,
  input  logic                     sram_rvalid_i,
  input  logic [DATA_WIDTH-1:0]    sram_rdata_i,
  input  logic                     sram_err_i,

  // Register target
  output logic                     regs_req_o,
  input  logic                     regs_gnt_i,
  output logic                     regs_we_o,
  output logic [obi_pkg::BE_W-1:0] regs_be_o,
  output logic [ADDR_WIDTH-1:0]    regs_addr_o,
  output logic [DATA_WIDTH-1:0]    regs_wdata_o,
  input  logic                     regs_rvalid_i,
  input  logic [DATA_WIDTH-1:0]    regs_rdata_i,
  input  logic                     regs_err_i
);

  localparam logic [ADDR_WIDTH-1:0] SRAM_LO = ADDR_WIDTH'(obi_pkg::SRAM_BASE);
  localparam logic [ADDR_WIDTH-1:0] SRAM_HI =
    ADDR_WIDTH'(obi_pkg::SRAM_BASE + SRAM_DEPTH * obi_pkg::BE_W);
  localparam logic [ADDR_WIDTH-1:0] REGS_LO = ADDR_WIDTH'(obi_pkg::REGS_BASE);
  localparam logic [ADDR_WIDTH-1:0] REGS_HI =
    ADDR_WIDTH'(obi_pkg::REGS_BASE + obi_pkg::REGS_SIZE);

  typedef enum logic [1:0] {
    ROUTE_SRAM,
    ROUTE_REGS,
    ROUTE_ERR
  } route_e;

  route_e route_q;
  logic   err_rvalid_q;
  logic   sram_hit;
  logic   regs_hit;

  assign sram_hit = (m_addr_i >= SRAM_LO) && (m_addr_i < SRAM_HI);
  assign regs_hit = (m_addr_i >= REGS_LO) && (m_addr_i < REGS_HI);

  // Targets see window-relative addresses
  assign sram_req_o   = m_req_i && sram_hit;
  assign sram_we_o    = m_we_i;
  assign sram_be_o    = m_be_i;
  assign sram_addr_o  = m_addr_i - SRAM_LO;
  assign sram_wdata_o = m_wdata_i;

  assign regs_req_o   = m_req_i && regs_hit;
  assign regs_we_o    = m_we_i;
  assign regs_be_o    = m_be_i;
  assign regs_addr_o  = m_addr_i - REGS_LO;
  assign regs_wdata_o = m_wdata_i;

  // Unmapped requests are granted here
  assign m_gnt_o = sram_hit ? sram_gnt_i : (regs_hit ? regs_gnt_i : m_req_i);

  always_ff @(posedge s00_axi_aclk) begin
    if (reset_i) begin
      route_q      <= ROUTE_SRAM;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= m_req_i && m_gnt_o && !sram_hit && !regs_hit;
      if (m_req_i && m_gnt_o) begin
        route_q <= sram_hit ? ROUTE_SRAM : (regs_hit ? ROUTE_REGS : ROUTE_ERR);
      end
    end
  end

  // Response merge
  always_comb begin
    case (route_q)
      ROUTE_SRAM: begin
        m_rvalid_o = sram_rvalid_i;
        m_rdata_o  = sram_rdata_i;
        m_err_o    = sram_err_i;
      end
      ROUTE_REGS: begin
        m_rvalid_o = regs_rvalid_i;
        m_rdata_o  = regs_rdata_i;
        m_err_o    = regs_err_i;
      end
      default: begin
        m_rvalid_o = err_rvalid_q;
        m_rdata_o  = '0;
        m_err_o    = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/obi_sram.sv
`timescale 1ns/1ps

module obi_sram #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int SRAM_DEPTH = 256
) (
  input  logic                     s00_axi_aclk,
  input  logic                     req_i,
  output logic                     gnt_o,
  input  logic                     we_i,
  input  logic [obi_pkg::BE_W-1:0] be_i,
  input  logic [ADDR_WIDTH-1:0]    addr_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  output logic                     rvalid_o,
  output logic [DATA_WIDTH-1:0]    rdata_o,
  output logic                     err_o
);

  localparam int OFS_W = $clog2(obi_pkg::BE_W);
  localparam int IDX_W = $clog2(SRAM_DEPTH);

  logic [DATA_WIDTH-1:0] mem_q [SRAM_DEPTH];
  logic [IDX_W-1:0]      idx;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;

  // Word index from the byte address
  assign idx = addr_i[OFS_W +: IDX_W];

  // Never stalls
  assign gnt_o = req_i;

  always_ff @(posedge s00_axi_aclk) begin
    if (req_i && we_i) begin
      for (int b = 0; b < obi_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge s00_axi_aclk) begin
    rvalid_q <= req_i;
    if (req_i && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = 1'b0;

endmodule

//--- logic/obi_status_regs.sv
`timescale 1ns/1ps

module obi_status_regs #(
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    DATA_WIDTH = 32,
  parameter logic [DATA_WIDTH-1:0] ID_VALUE   = '0
) (
  input  logic                     s00_axi_aclk,
  input  logic                     reset_i,
  input  logic                     req_i,
  output logic                     gnt_o,
  input  logic                     we_i,
  input  logic [obi_pkg::BE_W-1:0] be_i,
  input  logic [ADDR_WIDTH-1:0]    addr_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  output logic                     rvalid_o,
  output logic [DATA_WIDTH-1:0]    rdata_o,
  output logic                     err_o
);

  logic [obi_pkg::REG_OFS_W-1:0] ofs;
  logic                          ofs_valid;
  logic [DATA_WIDTH-1:0]         scratch_q;
  logic [DATA_WIDTH-1:0]         wcount_q;
  logic                          rvalid_q;
  logic                          err_q;
  logic [DATA_WIDTH-1:0]         rdata_q;
  logic [DATA_WIDTH-1:0]         rd_word;

  assign ofs   = addr_i[obi_pkg::REG_OFS_W-1:0];
  assign gnt_o = req_i;

  // Read mux, reserved offset reads as zero with err
  always_comb begin
    ofs_valid = 1'b1;
    case (ofs)
      obi_pkg::REG_ID_OFS:      rd_word = ID_VALUE;
      obi_pkg::REG_SCRATCH_OFS: rd_word = scratch_q;
      obi_pkg::REG_WCOUNT_OFS:  rd_word = wcount_q;
      default: begin
        rd_word   = '0;
        ofs_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge s00_axi_aclk) begin
    if (reset_i) begin
      scratch_q <= '0;
      wcount_q  <= '0;
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && !ofs_valid;
      if (req_i && we_i && ofs_valid) begin
        // ID and count ignore the data but the write still counts
        wcount_q <= wcount_q + DATA_WIDTH'(1);
        if (ofs == obi_pkg::REG_SCRATCH_OFS) begin
          for (int b = 0; b < obi_pkg::BE_W; b++) begin
            if (be_i[b]) begin
              scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge s00_axi_aclk) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : rd_word;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

endmodule

//--- project.f
common/axil_pkg.sv
common/obi_pkg.sv
axi2obi/axi2obi.sv
logic/obi_splitter.sv
logic/obi_sram.sv
logic/obi_status_regs.sv
logic/axil_obi_subsys.sv
verif/axil_obi_props.sv
verif/tb_axil_obi.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_axil_obi

# The simulator exits non-zero on $fatal, tee keeps the log
./obj_dir/Vtb_axil_obi | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

//--- verif/axil_obi_props.sv
`timescale 1ns/1ps

module axi2obi_props #(
  parameter int DATA_WIDTH = 32
) (
  input logic                        s00_axi_aclk,
  input logic                        reset_i,
  input logic                        s00_axi_arvalid_i,
  input logic                        s00_axi_arready_o,
  input logic                        s00_axi_rvalid_o,
  input logic                        s00_axi_rready_i,
  input logic [DATA_WIDTH-1:0]       s00_axi_rdata_o,
  input logic [axil_pkg::RESP_W-1:0] s00_axi_rresp_o,
  input logic                        s00_axi_awvalid_i,
  input logic                        s00_axi_wvalid_i,
  input logic                        s00_axi_awready_o,
  input logic                        s00_axi_wready_o,
  input logic                        s00_axi_bvalid_o,
  input logic                        s00_axi_bready_i,
  input logic [axil_pkg::RESP_W-1:0] s00_axi_bresp_o,
  input logic                        req_o,
  input logic                        gnt_i
);

  // Fixed latency from address handshake to response
  ar_latency: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    s00_axi_arvalid_i && s00_axi_arready_o |-> ##3 s00_axi_rvalid_o)
    else $error("R response not 3 cycles after AR handshake");
  aw_latency: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    s00_axi_awready_o |-> ##3 s00_axi_bvalid_o)
    else $error("B response not 3 cycles after AW handshake");

  // Responses held under back-pressure
  r_stable: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    s00_axi_rvalid_o && !s00_axi_rready_i |=> s00_axi_rvalid_o &&
    $stable(s00_axi_rdata_o) && $stable(s00_axi_rresp_o))
    else $error("R channel changed before handshake");
  b_stable: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    s00_axi_bvalid_o && !s00_axi_bready_i |=> s00_axi_bvalid_o && $stable(s00_axi_bresp_o))
    else $error("B channel changed before handshake");

  // AW and W taken together, only on a valid pair, and never over a waiting AR
  aw_with_w: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    s00_axi_awready_o || s00_axi_wready_o |->
    s00_axi_awready_o && s00_axi_wready_o && s00_axi_awvalid_i && s00_axi_wvalid_i &&
    !s00_axi_arvalid_i)
    else $error("AW and W not accepted together on a valid pair");

  // Targets never stall, so each req is granted at once and then dropped
  req_held: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
    req_o |-> gnt_i ##1 !req_o)
    else $error("OBI req not granted at once or held after gnt");

endmodule

bind axi2obi axi2obi_props #(
  .DATA_WIDTH(DATA_WIDTH)
) axi2obi_props_i (.*);

//--- verif/tb_axil_obi.sv
`timescale 1ns/1ps

module tb_axil_obi;

  localparam int          DEPTH  = 256;
  localparam logic [31:0] ID_VAL = 32'hA5B0_0001;
  localparam logic [31:0] REGS   = 32'h0000_1000;
  localparam logic [1:0]  OKAY   = axil_pkg::RESP_OKAY;
  localparam logic [1:0]  SLVERR = axil_pkg::RESP_SLVERR;

  logic        s00_axi_aclk = 1'b0;
  logic        reset_i;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [2:0]  awprot, arprot;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;

  // Reference model
  logic [31:0] sram_m [DEPTH];
  logic [31:0] scratch_m;
  logic [31:0] wcount_m;

  always #5 s00_axi_aclk = ~s00_axi_aclk;

  axil_obi_subsys #(.SRAM_DEPTH(DEPTH), .ID_VALUE(ID_VAL)) axil_obi_subsys_i (
    .s00_axi_aclk, .reset_i,
    .s00_axi_awaddr_i(awaddr), .s00_axi_awprot_i(awprot), .s00_axi_awvalid_i(awvalid),
    .s00_axi_awready_o(awready), .s00_axi_wdata_i(wdata), .s00_axi_wstrb_i(wstrb),
    .s00_axi_wvalid_i(wvalid), .s00_axi_wready_o(wready), .s00_axi_bresp_o(bresp),
    .s00_axi_bvalid_o(bvalid), .s00_axi_bready_i(bready),
    .s00_axi_araddr_i(araddr), .s00_axi_arprot_i(arprot), .s00_axi_arvalid_i(arvalid),
    .s00_axi_arready_o(arready), .s00_axi_rdata_o(rdata), .s00_axi_rresp_o(rresp),
    .s00_axi_rvalid_o(rvalid), .s00_axi_rready_i(rready)
  );

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] d, logic [3:0] s);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) r[8*b +: 8] = d[8*b +: 8];
    end
    return r;
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic take_b(input logic [1:0] exp_resp);
    int d;
    d = $urandom_range(0, 6);
    @(negedge s00_axi_aclk);
    while (!bvalid) @(negedge s00_axi_aclk);
    repeat (d) @(negedge s00_axi_aclk);
    check(bvalid && bresp == exp_resp, $sformatf("bresp %0h, expected %0h", bresp, exp_resp));
    @(posedge s00_axi_aclk) bready <= 1'b1;
    @(posedge s00_axi_aclk) bready <= 1'b0;
  endtask

  task automatic take_r(input logic [31:0] exp_data, input logic [1:0] exp_resp);
    int d;
    d = $urandom_range(0, 6);
    @(negedge s00_axi_aclk);
    while (!rvalid) @(negedge s00_axi_aclk);
    repeat (d) @(negedge s00_axi_aclk);
    check(rvalid && rresp == exp_resp, $sformatf("rresp %0h, expected %0h", rresp, exp_resp));
    check(rdata == exp_data, $sformatf("rdata %08h, expected %08h", rdata, exp_data));
    @(posedge s00_axi_aclk) rready <= 1'b1;
    @(posedge s00_axi_aclk) rready <= 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                            input logic [1:0] exp_resp);
    @(posedge s00_axi_aclk);
    awaddr  <= a;
    wdata   <= d;
    wstrb   <= s;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge s00_axi_aclk);
    while (!awready) @(negedge s00_axi_aclk);
    @(posedge s00_axi_aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    take_b(exp_resp);
  endtask

  task automatic axil_read(input logic [31:0] a, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    @(posedge s00_axi_aclk);
    araddr  <= a;
    arvalid <= 1'b1;
    @(negedge s00_axi_aclk);
    while (!arready) @(negedge s00_axi_aclk);
    @(posedge s00_axi_aclk) arvalid <= 1'b0;
    take_r(exp_data, exp_resp);
  endtask

  // Read and write offered in the same cycle
  task automatic read_write_collide(input int idx, input logic [31:0] d);
    @(posedge s00_axi_aclk);
    araddr  <= 32'(idx * 4);
    awaddr  <= 32'(idx * 4);
    wdata   <= d;
    wstrb   <= 4'hF;
    arvalid <= 1'b1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge s00_axi_aclk);
    check(arready && !awready && !wready, "read was not taken before the write");
    @(posedge s00_axi_aclk) arvalid <= 1'b0;
    take_r(sram_m[idx], OKAY);
    @(negedge s00_axi_aclk);
    while (!awready) @(negedge s00_axi_aclk);
    @(posedge s00_axi_aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    take_b(OKAY);
    sram_m[idx] = d;
  endtask

  // 200 transactions at 20 cycles each
  initial begin
    #(200 * 20 * 10);
    $display("Timeout: the run did not finish in time");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    int          idx;
    logic [31:0] d;
    logic [3:0]  s;
    void'($urandom(60633));
    {awaddr, wdata, araddr, wstrb, awprot, arprot} = '0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    scratch_m = '0;
    wcount_m  = '0;
    reset_i   = 1'b1;
    repeat (2) @(posedge s00_axi_aclk);
    reset_i <= 1'b0;
    @(negedge s00_axi_aclk);
    check(!arready && !awready && !wready && !rvalid && !bvalid, "outputs active after reset");

    // Full-strobe SRAM writes, then read back
    for (int i = 0; i < 24; i++) begin
      idx = $urandom_range(0, DEPTH - 1);
      d = $urandom;
      axil_write(32'(idx * 4), d, 4'hF, OKAY);
      sram_m[idx] = d;
      axil_read(32'(idx * 4), sram_m[idx], OKAY);
    end

    // Partial strobes on SRAM and scratch
    for (int i = 0; i < 8; i++) begin
      idx = $urandom_range(0, DEPTH - 1);
      d = $urandom;
      axil_write(32'(idx * 4), d, 4'hF, OKAY);
      sram_m[idx] = d;
      axil_read(32'(idx * 4), sram_m[idx], OKAY);
      d = $urandom;
      s = 4'($urandom_range(1, 14));
      axil_write(32'(idx * 4), d, s, OKAY);
      sram_m[idx] = merge_bytes(sram_m[idx], d, s);
      axil_read(32'(idx * 4), sram_m[idx], OKAY);
      axil_write(REGS + 32'h4, d, ~s, OKAY);
      scratch_m = merge_bytes(scratch_m, d, ~s);
      wcount_m++;
      axil_read(REGS + 32'h4, scratch_m, OKAY);
    end

    // ID is read-only, write count follows every register write
    axil_write(REGS, 32'hFFFF_FFFF, 4'hF, OKAY);
    wcount_m++;
    axil_read(REGS, ID_VAL, OKAY);
    axil_read(REGS + 32'h8, wcount_m, OKAY);

    // Decode errors and the reserved offset
    axil_write(32'h0000_2000, 32'h1234_5678, 4'hF, SLVERR);
    axil_write(REGS + 32'hC, 32'h1234_5678, 4'hF, SLVERR);
    axil_read(32'h0000_0800, 32'h0, SLVERR);
    axil_read(REGS + 32'h10, 32'h0, SLVERR);
    axil_read(REGS + 32'hC, 32'h0, SLVERR);
    axil_read(REGS + 32'h8, wcount_m, OKAY);
    axil_read(REGS + 32'h4, scratch_m, OKAY);

    read_write_collide(idx, 32'hCAFE_0042);
    axil_read(32'(idx * 4), sram_m[idx], OKAY);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
